// ==== include/analog_config.svh ====
////////////////////////////////////////////////////////////
// Widths and counts for the ADC/DAC data path
// Single adc_clk domain, two channels A and B
// ADC pin word carries two reserved bits at the bottom
////////////////////////////////////////////////////////////

`ifndef ANALOG_CONFIG_SVH
`define ANALOG_CONFIG_SVH

// Channel count, ports are still named A and B
`define ANALOG_NUM_CH 2

// Raw word on the ADC pins
`define ADC_RAW_W     16

// Reserved low bits of the raw word, dropped at capture
`define ADC_PAD_BITS  2

// Converted sample and DAC code width
`define SAMPLE_W      14

`endif

// ==== design/adc_pkg.sv ====
////////////////////////////////////////////////////////////
// ADC side words, the converted sample type and the
// negative slope code rule shared by both converters
////////////////////////////////////////////////////////////

`default_nettype none

`include "analog_config.svh"

package adc_pkg;

  typedef logic        [`ADC_RAW_W-1:0] adc_raw_t;  // Pin word incl. padding
  typedef logic signed [`SAMPLE_W-1:0]  sample_t;   // Two's complement sample

  // Pin code of a zero sample (midscale, negative slope)
  localparam logic [`SAMPLE_W-1:0] MID_CODE = {1'b0, {(`SAMPLE_W-1){1'b1}}};

  // Same rule both ways: keep MSB, invert the rest
  function automatic logic [`SAMPLE_W-1:0] flip_slope(input logic [`SAMPLE_W-1:0] code);
    return {code[`SAMPLE_W-1], ~code[`SAMPLE_W-2:0]};
  endfunction

endpackage

`default_nettype wire

// ==== design/dac_pkg.sv ====
////////////////////////////////////////////////////////////
// DAC side types: raw sum, saturation limits, DAC code
// Sum is one bit wider than a sample, so a single
// overflow bit is enough to detect clipping
////////////////////////////////////////////////////////////

`default_nettype none

`include "analog_config.svh"

package dac_pkg;

  import adc_pkg::sample_t;

  // Generator + controller, one guard bit
  typedef logic signed [`SAMPLE_W:0] sum_t;

  // Unsigned negative slope code on the DAC pins
  typedef logic [`SAMPLE_W-1:0] dac_code_t;

  // Saturation limits of a 14-bit sample
  localparam sample_t SAT_MAX = {1'b0, {(`SAMPLE_W-1){1'b1}}};  // Most positive
  localparam sample_t SAT_MIN = {1'b1, {(`SAMPLE_W-1){1'b0}}};  // Most negative

  // Zero sample after reset
  localparam sample_t SAMPLE_ZERO = '0;

endpackage

`default_nettype wire

// ==== design/adc_frontend.sv ====
////////////////////////////////////////////////////////////
// ADC capture for both channels
// Raw words go through one shared IO-stage register bank
// Output is combinational after that register, so the
// ADC path has one cycle of latency
// Loopback bypasses the ADC with no added delay
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "analog_config.svh"

module adc_frontend (
  input  logic              adc_clk,
  input  logic              rst_i,
  // ADC pins
  input  adc_pkg::adc_raw_t adc_dat_a_i,
  input  adc_pkg::adc_raw_t adc_dat_b_i,
  // Loopback source, DAC-bound samples
  input  logic              digital_loop_i,
  input  adc_pkg::sample_t  loop_a_i,
  input  adc_pkg::sample_t  loop_b_i,
  // Converted samples
  output adc_pkg::sample_t  adc_dat_a_o,
  output adc_pkg::sample_t  adc_dat_b_o
);

  import adc_pkg::*;

  ////////////////////////////////////////////////////////////
  // Pin-side registers
  ////////////////////////////////////////////////////////////

  logic [`SAMPLE_W-1:0] raw_a_q;  // Upper bits of pin word A
  logic [`SAMPLE_W-1:0] raw_b_q;  // Upper bits of pin word B

  // Reserved low bits are never stored
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      raw_a_q <= MID_CODE;  // Reads back as zero sample
      raw_b_q <= MID_CODE;
    end
    else
    begin
      raw_a_q <= adc_dat_a_i[`ADC_RAW_W-1:`ADC_PAD_BITS];
      raw_b_q <= adc_dat_b_i[`ADC_RAW_W-1:`ADC_PAD_BITS];
    end
  end

  ////////////////////////////////////////////////////////////
  // Conversion and loopback select
  ////////////////////////////////////////////////////////////

  sample_t conv_a;
  sample_t conv_b;

  // Negative slope unsigned -> two's complement
  assign conv_a = sample_t'(flip_slope(raw_a_q));
  assign conv_b = sample_t'(flip_slope(raw_b_q));

  // Loop takes the current saturated sample directly
  assign adc_dat_a_o = digital_loop_i ? loop_a_i : conv_a;
  assign adc_dat_b_o = digital_loop_i ? loop_b_i : conv_b;

endmodule

`default_nettype wire

// ==== design/dac_channel.sv ====
////////////////////////////////////////////////////////////
// One DAC channel: generator + controller sum, saturated
// to 14 bits and registered once
// clip_o is high for exactly the registered samples that
// were limited
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "analog_config.svh"

module dac_channel (
  input  logic             adc_clk,
  input  logic             rst_i,
  input  adc_pkg::sample_t gen_dat_i,  // Generator sample
  input  adc_pkg::sample_t ctl_dat_i,  // Controller sample
  output adc_pkg::sample_t sat_dat_o,  // Saturated, registered
  output logic             clip_o      // Sample was limited
);

  import adc_pkg::*;
  import dac_pkg::*;

  sum_t    sum;
  logic    ovf;
  sample_t sat;

  // Sign extend both operands to the guard width
  assign sum = sum_t'(gen_dat_i) + sum_t'(ctl_dat_i);

  // Top two sum bits disagree -> out of 14-bit range
  assign ovf = sum[`SAMPLE_W] ^ sum[`SAMPLE_W-1];

  // Limit by the sign of the full sum
  always_comb
  begin
    if (ovf)
      sat = sum[`SAMPLE_W] ? SAT_MIN : SAT_MAX;
    else
      sat = sample_t'(sum[`SAMPLE_W-1:0]);  // In range, drop guard bit
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  sample_t sat_q;
  logic    clip_q;

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      sat_q  <= SAMPLE_ZERO;
      clip_q <= 1'b0;
    end
    else
    begin
      sat_q  <= sat;
      clip_q <= ovf;  // Tracks the sample it belongs to
    end
  end

  assign sat_dat_o = sat_q;
  assign clip_o    = clip_q;

endmodule

`default_nettype wire

// ==== design/dac_interleave.sv ====
////////////////////////////////////////////////////////////
// Word-interleaved DAC bus from two channels
// Select toggles every cycle, so each channel is updated
// at half the adc_clk rate
// A pair is captured when select rises: A while select is
// high, B on the following low cycle
// DAC reset is held one cycle past rst_i
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dac_interleave (
  input  logic                adc_clk,
  input  logic                rst_i,
  input  adc_pkg::sample_t    sat_a_i,    // Channel A sample
  input  adc_pkg::sample_t    sat_b_i,    // Channel B sample
  output dac_pkg::dac_code_t  dac_dat_o,  // Shared DAC data
  output logic                dac_sel_o,  // High = channel A
  output logic                dac_rst_o   // DAC reset, stretched
);

  import adc_pkg::*;
  import dac_pkg::*;

  dac_code_t code_a;
  dac_code_t code_b;

  // Two's complement -> negative slope offset code
  assign code_a = dac_code_t'(flip_slope(sat_a_i));
  assign code_b = dac_code_t'(flip_slope(sat_b_i));

  ////////////////////////////////////////////////////////////
  // Select toggle and reset stretch
  ////////////////////////////////////////////////////////////

  logic sel_q;
  logic rst_q;

  always_ff @(posedge adc_clk)
  begin
    rst_q <= rst_i;  // One cycle longer than rst_i
    if (rst_i)
      sel_q <= 1'b0;
    else
      sel_q <= ~sel_q;
  end

  ////////////////////////////////////////////////////////////
  // Data register and B holding stage
  ////////////////////////////////////////////////////////////

  dac_code_t dat_q;
  dac_code_t hold_b_q;  // B word of the current pair

  always_ff @(posedge adc_clk)
  begin
    if (!sel_q)
      hold_b_q <= code_b;  // Pair captured as select rises
    if (rst_i || rst_q)
      dat_q <= dac_code_t'(MID_CODE);  // Zero sample on the pins
    else if (!sel_q)
      dat_q <= code_a;     // Select going high, A first
    else
      dat_q <= hold_b_q;   // Select going low, B of same pair
  end

  assign dac_dat_o = dat_q;
  assign dac_sel_o = sel_q;
  assign dac_rst_o = rst_q;

endmodule

`default_nettype wire

// ==== design/analog_top.sv ====
////////////////////////////////////////////////////////////
// Analog data path top, single adc_clk domain
// Generator and controller streams come in as ports, one
// sample per cycle, no handshake and no stalls
// Saturated samples feed both the DAC bus and loopback
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "analog_config.svh"

module analog_top (
  input  logic               adc_clk,
  input  logic               rst_i,
  // ADC pins
  input  adc_pkg::adc_raw_t  adc_dat_a_i,
  input  adc_pkg::adc_raw_t  adc_dat_b_i,
  // Sample streams to be summed per channel
  input  adc_pkg::sample_t   gen_dat_a_i,
  input  adc_pkg::sample_t   gen_dat_b_i,
  input  adc_pkg::sample_t   ctl_dat_a_i,
  input  adc_pkg::sample_t   ctl_dat_b_i,
  input  logic               digital_loop_i,  // DAC samples replace ADC
  // Converted ADC samples
  output adc_pkg::sample_t   adc_dat_a_o,
  output adc_pkg::sample_t   adc_dat_b_o,
  // DAC pins
  output dac_pkg::dac_code_t dac_dat_o,
  output logic               dac_sel_o,
  output logic               dac_rst_o,
  // Saturation flags
  output logic               clip_a_o,
  output logic               clip_b_o
);

  import adc_pkg::*;

  // Per-channel arrays, index 0 = A, 1 = B
  sample_t gen_dat [`ANALOG_NUM_CH];
  sample_t ctl_dat [`ANALOG_NUM_CH];
  sample_t sat_dat [`ANALOG_NUM_CH];
  logic    clip    [`ANALOG_NUM_CH];

  assign gen_dat[0] = gen_dat_a_i;
  assign gen_dat[1] = gen_dat_b_i;
  assign ctl_dat[0] = ctl_dat_a_i;
  assign ctl_dat[1] = ctl_dat_b_i;

  ////////////////////////////////////////////////////////////
  // ADC front end
  ////////////////////////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop_i),
    .loop_a_i       (sat_dat[0]),  // Loop source A
    .loop_b_i       (sat_dat[1]),  // Loop source B
    .adc_dat_a_o    (adc_dat_a_o),
    .adc_dat_b_o    (adc_dat_b_o)
  );

  ////////////////////////////////////////////////////////////
  // Summation and saturation, one per channel
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < `ANALOG_NUM_CH; ch++)
  begin : g_ch
    dac_channel u_dac_ch (
      .adc_clk   (adc_clk),
      .rst_i     (rst_i),
      .gen_dat_i (gen_dat[ch]),
      .ctl_dat_i (ctl_dat[ch]),
      .sat_dat_o (sat_dat[ch]),
      .clip_o    (clip[ch])
    );
  end

  assign clip_a_o = clip[0];
  assign clip_b_o = clip[1];

  // DAC bus, A/B interleaved
  dac_interleave u_dac_bus (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .sat_a_i   (sat_dat[0]),
    .sat_b_i   (sat_dat[1]),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
////////////////////////////////////////////////////////////
// Clock and reset source for the analog path testbench
// adc_clk starts low, 8 ns period
// rst_o high for 10 rising edges, released on a falling edge
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 10
) (
  output logic adc_clk,
  output logic rst_o
);

  initial
  begin
    adc_clk = 1'b0;
    forever #(PERIOD_NS / 2) adc_clk = ~adc_clk;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_o = 1'b0;  // Same edge as all other stimulus
  end

endmodule

`default_nettype wire

// ==== testbench/analog_chk.sv ====
////////////////////////////////////////////////////////////
// Protocol checks bound into analog_top
// Select toggle, reset stretch and clip sanity only
// Data values are checked by the testbench itself
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module analog_chk (
  input logic             adc_clk,
  input logic             rst_i,
  input logic             dac_sel_i,
  input logic             dac_rst_i,
  input adc_pkg::sample_t gen_a_i,
  input adc_pkg::sample_t gen_b_i,
  input adc_pkg::sample_t ctl_a_i,
  input adc_pkg::sample_t ctl_b_i,
  input logic             clip_a_i,
  input logic             clip_b_i
);

  int assert_fail_cnt = 0;  // Count of failed assertions

  // Select flips on every edge once out of reset
  a_sel_toggle: assert property (@(posedge adc_clk) disable iff (rst_i)
    !rst_i |=> (dac_sel_i != $past(dac_sel_i)))
    else
    begin
      $error("dac_sel_o did not toggle");
      assert_fail_cnt++;
    end

  // DAC reset still high one cycle after rst_i
  a_rst_stretch: assert property (@(posedge adc_clk)
    rst_i |=> dac_rst_i)
    else
    begin
      $error("dac_rst_o low in the cycle after rst_i");
      assert_fail_cnt++;
    end

  // Zero + zero can never clip
  a_clip_a_zero: assert property (@(posedge adc_clk) disable iff (rst_i)
    (gen_a_i == '0 && ctl_a_i == '0) |=> !clip_a_i)
    else
    begin
      $error("clip_a_o high after zero inputs on channel A");
      assert_fail_cnt++;
    end

  a_clip_b_zero: assert property (@(posedge adc_clk) disable iff (rst_i)
    (gen_b_i == '0 && ctl_b_i == '0) |=> !clip_b_i)
    else
    begin
      $error("clip_b_o high after zero inputs on channel B");
      assert_fail_cnt++;
    end

endmodule

bind analog_top analog_chk u_chk (
  .adc_clk   (adc_clk),
  .rst_i     (rst_i),
  .dac_sel_i (dac_sel_o),
  .dac_rst_i (dac_rst_o),
  .gen_a_i   (gen_dat_a_i),
  .gen_b_i   (gen_dat_b_i),
  .ctl_a_i   (ctl_dat_a_i),
  .ctl_b_i   (ctl_dat_b_i),
  .clip_a_i  (clip_a_o),
  .clip_b_i  (clip_b_o)
);

`default_nettype wire

// ==== testbench/analog_tb.sv ====
////////////////////////////////////////////////////////////
// Vector driven testbench for analog_top
// Vectors come from testbench/analog_tests.txt, path is
// relative to the project root (run from there)
// Each vector is held 6 cycles, outputs sampled in the
// last two, so exact pipeline latency does not matter
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "analog_config.svh"

module analog_tb;

  import adc_pkg::*;
  import dac_pkg::*;

  localparam int MAX_VEC  = 64;
  localparam int NUM_FLD  = 13;
  localparam int HOLD_CYC = 6;
  localparam int RST_CYC  = 10;
  // Field order of one vector line
  localparam int F_ADC_A   = 0;
  localparam int F_ADC_B   = 1;
  localparam int F_GEN_A   = 2;
  localparam int F_GEN_B   = 3;
  localparam int F_CTL_A   = 4;
  localparam int F_CTL_B   = 5;
  localparam int F_LOOP    = 6;
  localparam int F_XADC_A  = 7;
  localparam int F_XADC_B  = 8;
  localparam int F_XDAC_A  = 9;
  localparam int F_XDAC_B  = 10;
  localparam int F_XCLIP_A = 11;
  localparam int F_XCLIP_B = 12;
  localparam logic [`SAMPLE_W-1:0] ZERO_CODE = 14'h1FFF;  // Midscale, zero sample

  logic      adc_clk;
  logic      rst;
  adc_raw_t  adc_a, adc_b;
  sample_t   gen_a, gen_b, ctl_a, ctl_b;
  logic      loop;
  sample_t   adc_out_a, adc_out_b;
  dac_code_t dac_dat;
  logic      dac_sel, dac_rst, clip_a, clip_b;

  logic [15:0] vec [MAX_VEC][NUM_FLD];
  int     n_vec = 0;
  int     cur_test = 0;
  int     err_cnt = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;  // 0 until vectors are loaded
  integer seed = 7;

  tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(RST_CYC)) u_clk (.adc_clk(adc_clk), .rst_o(rst));

  analog_top dut0 (
    .adc_clk (adc_clk), .rst_i (rst),
    .adc_dat_a_i (adc_a), .adc_dat_b_i (adc_b),
    .gen_dat_a_i (gen_a), .gen_dat_b_i (gen_b),
    .ctl_dat_a_i (ctl_a), .ctl_dat_b_i (ctl_b),
    .digital_loop_i (loop),
    .adc_dat_a_o (adc_out_a), .adc_dat_b_o (adc_out_b),
    .dac_dat_o (dac_dat), .dac_sel_o (dac_sel), .dac_rst_o (dac_rst),
    .clip_a_o (clip_a), .clip_b_o (clip_b)
  );

  // Compare and log one mismatch
  task automatic check_value(input logic [`SAMPLE_W-1:0] got,
                             input logic [`SAMPLE_W-1:0] exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t ns: test %0d, %s is %h, expected %h",
               $time, cur_test, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before)
      pass_cnt++;
    else
      fail_cnt++;
    $display("Test %0d (%s): %s", cur_test, name, (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic load_vectors();
    int          fd;
    int          got;
    string       line;
    logic [15:0] fld [NUM_FLD];
    fd = $fopen("testbench/analog_tests.txt", "r");
    if (fd == 0)
      $display("Could not open testbench/analog_tests.txt");
    else
    begin
      while (!$feof(fd) && n_vec < MAX_VEC)
      begin
        line = "";
        got = $fgets(line, fd);
        if (got > 1 && line[0] != "#")  // Skip comments and blank lines
        begin
          got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                        fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
          if (got == NUM_FLD)
          begin
            for (int k = 0; k < NUM_FLD; k++)
              vec[n_vec][k] = fld[k];
            n_vec++;
          end
          else
          begin
            err_cnt++;
            $display("Vector line has %0d fields instead of %0d: %s", got, NUM_FLD, line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Reset values and the one-cycle DAC reset stretch
  task automatic check_reset();
    int errs_before;
    errs_before = err_cnt;
    repeat (2) @(negedge adc_clk);
    check_value(dac_rst, 1'b1, "dac_rst_o in reset");
    @(negedge rst);
    check_value(dac_sel, 1'b0, "dac_sel_o");
    check_value(dac_dat, ZERO_CODE, "dac_dat_o");
    check_value(clip_a, 1'b0, "clip_a_o");
    check_value(clip_b, 1'b0, "clip_b_o");
    check_value(adc_out_a, '0, "adc_dat_a_o");
    check_value(adc_out_b, '0, "adc_dat_b_o");
    check_value(dac_rst, 1'b1, "dac_rst_o after rst_i");
    @(negedge adc_clk);
    check_value(dac_rst, 1'b0, "dac_rst_o two cycles after rst_i");
    check_value(dac_dat, ZERO_CODE, "dac_dat_o in stretched reset");
    report_test("reset", errs_before);
  endtask

  // Bus phase picks which expected code applies
  task automatic check_dac(input int idx);
    if (dac_sel)
      check_value(dac_dat, vec[idx][F_XDAC_A], "dac_dat_o phase A");
    else
      check_value(dac_dat, vec[idx][F_XDAC_B], "dac_dat_o phase B");
  endtask

  task automatic run_vector(input int idx);
    int     errs_before;
    integer pad_a;
    integer pad_b;
    errs_before = err_cnt;
    cur_test = idx + 1;
    pad_a = $random(seed);  // Padding bits must be ignored
    pad_b = $random(seed);
    adc_a = {vec[idx][F_ADC_A][`ADC_RAW_W-1:`ADC_PAD_BITS], pad_a[`ADC_PAD_BITS-1:0]};
    adc_b = {vec[idx][F_ADC_B][`ADC_RAW_W-1:`ADC_PAD_BITS], pad_b[`ADC_PAD_BITS-1:0]};
    gen_a = vec[idx][F_GEN_A][`SAMPLE_W-1:0];
    gen_b = vec[idx][F_GEN_B][`SAMPLE_W-1:0];
    ctl_a = vec[idx][F_CTL_A][`SAMPLE_W-1:0];
    ctl_b = vec[idx][F_CTL_B][`SAMPLE_W-1:0];
    loop  = vec[idx][F_LOOP][0];
    repeat (HOLD_CYC - 1) @(negedge adc_clk);
    check_dac(idx);
    @(negedge adc_clk);
    check_dac(idx);  // Other bus phase
    check_value(adc_out_a, vec[idx][F_XADC_A], "adc_dat_a_o");
    check_value(adc_out_b, vec[idx][F_XADC_B], "adc_dat_b_o");
    check_value(clip_a, vec[idx][F_XCLIP_A], "clip_a_o");
    check_value(clip_b, vec[idx][F_XCLIP_B], "clip_b_o");
    report_test("vector", errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////

  always @(posedge adc_clk)
  begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    adc_a = 16'h7FFC;  // Midscale pin word
    adc_b = 16'h7FFC;
    gen_a = '0;
    gen_b = '0;
    ctl_a = '0;
    ctl_b = '0;
    loop  = 1'b0;
    load_vectors();
    if (n_vec == 0)
    begin
      $display("No test vectors were loaded, nothing to run");
      $display("TESTS FAILED");
      $finish;
    end
    else
    begin
      cycle_limit = 8 * n_vec * HOLD_CYC + RST_CYC;
      check_reset();
      for (int i = 0; i < n_vec; i++)
        run_vector(i);
      $display("Summary: %0d tests, %0d ok, %0d with mismatches, %0d errors, %0d assertion failures",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt, dut0.u_chk.assert_fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0 && dut0.u_chk.assert_fail_cnt == 0)
        $display("TESTS PASSED");
      else
        $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/analog_tests.txt ====
# Test vectors for analog_tb, all fields hex, one test per line
# Inputs: adc_a adc_b gen_a gen_b ctl_a ctl_b loop
# Expected: adc_out_a adc_out_b dac_code_a dac_code_b clip_a clip_b
# Raw ADC words have zero padding bits here, the testbench randomizes them
7FFC 7FFC 0000 0000 0000 0000 0 0000 0000 1FFF 1FFF 0 0
0000 FFFC 0000 0000 0000 0000 0 1FFF 2000 1FFF 1FFF 0 0
48D0 AAF0 0100 3F00 0023 0010 0 0DCB 3543 1EDC 20EF 0 0
2AF0 C004 1000 3000 0FFF 0FFF 0 1543 2FFE 0000 2000 0 0
7FFC 7FFC 1FFF 2000 0001 3FFF 0 0000 0000 0000 3FFF 1 1
7FFC 7FFC 1000 3000 1800 2800 0 0000 0000 0000 3FFF 1 1
7FFC 7FFC 1FFF 2000 0000 0000 0 0000 0000 0000 3FFF 0 0
48D0 AAF0 1800 0005 0900 3FFB 0 0DCB 3543 0000 1FFF 1 0
48D0 AAF0 0100 3F00 0023 0010 1 0123 3F10 1EDC 20EF 0 0
0000 FFFC 1FFF 2000 0001 3FFF 1 1FFF 2000 0000 3FFF 1 1
7FFC 7FFC 1FFF 2000 0001 3FFF 0 0000 0000 0000 3FFF 1 1
2AF0 C004 3E00 0400 3F00 0300 1 3D00 0700 22FF 18FF 0 0
5554 8888 0000 0000 0000 0000 0 0AAA 3DDD 1FFF 1FFF 0 0
7FFC 7FFC 0000 0000 0000 0000 0 0000 0000 1FFF 1FFF 0 0

// ==== analog_path.f ====
+incdir+include
design/adc_pkg.sv
design/dac_pkg.sv
design/adc_frontend.sv
design/dac_channel.sv
design/dac_interleave.sv
design/analog_top.sv
testbench/tb_clk_gen.sv
testbench/analog_chk.sv
testbench/analog_tb.sv
